// File: Makefile
TOP = lrelu_engine_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f lrelu_engine.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q -F "*** PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: lrelu_engine.f
rtl/lrelu_pkg.sv
rtl/lrelu_config_loader.sv
rtl/lrelu_coef_bank.sv
rtl/lrelu_datapath.sv
rtl/lrelu_engine.sv
verification/lrelu_engine_assertions.sv
verification/lrelu_engine_tb.sv

// File: rtl/lrelu_coef_bank.sv
module lrelu_coef_bank (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     clken,
  input  logic                                                     resetn_config,
  input  lrelu_pkg::cfg_write_t                                    cfg_write,
  input  logic                                                     s_valid,
  input  logic                                                     s_last,
  input  lrelu_pkg::user_t                                         s_user,
  input  logic [lrelu_pkg::UNITS-1:0][lrelu_pkg::WORD_WIDTH_IN-1:0] s_data,
  output lrelu_pkg::beat_in_t                                      beat,
  output lrelu_pkg::coef_t                                         coef,
  output logic signed [lrelu_pkg::WORD_WIDTH_OUT-1:0]              offset
);
  import lrelu_pkg::*;

  coef_t                               coef_mem [MEMBERS];
  logic signed [WORD_WIDTH_OUT-1:0]    d_q;
  logic [BITS_MEMBERS-1:0]             r_addr;
  logic [BITS_MEMBERS-1:0]             r_addr_max;
  logic                                accept;
  logic                                valid_q;
  logic                                last_q;
  user_t                               user_q;
  logic [UNITS-1:0][WORD_WIDTH_IN-1:0] data_q;

  assign accept     = clken && s_valid;
  assign r_addr_max = r_addr_max_lut(s_user.kw2);

  // coefficient store, offset and read pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_mem <= '{default: '0};
      d_q      <= '0;
      r_addr   <= '0;
    end else if (clken) begin
      if (!resetn_config) begin
        coef_mem <= '{default: '0};
        d_q      <= '0;
        r_addr   <= '0;
      end else begin
        if (cfg_write.en && cfg_write.to_offset) d_q <= cfg_write.word.offset.d;
        if (cfg_write.en && !cfg_write.to_offset) coef_mem[cfg_write.addr] <= cfg_write.word.coef;
        // wrap depends on kernel width of the current beat
        if (s_valid) r_addr <= (r_addr >= r_addr_max) ? '0 : r_addr + BITS_MEMBERS'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (clken) begin
      valid_q <= s_valid;
      last_q  <= s_valid && s_last;
    end
  end

  // first pipeline stage, beat with its coefficient
  always_ff @(posedge clk) begin
    if (accept) begin
      user_q <= s_user;
      data_q <= s_data;
      coef   <= coef_mem[r_addr];
      offset <= d_q;
    end
  end

  always_comb begin
    beat.valid = valid_q;
    beat.last  = last_q;
    beat.user  = user_q;
    beat.data  = data_q;
  end

endmodule

// File: rtl/lrelu_config_loader.sv
module lrelu_config_loader (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clken,
  input  logic                  resetn_config,
  input  logic                  s_valid_config,
  input  lrelu_pkg::cfg_word_u  s_config,
  output lrelu_pkg::cfg_write_t cfg_write,
  output logic                  count_config_full
);
  import lrelu_pkg::*;

  // beat 0 is the offset, beats 1..MEMBERS are scale/bias pairs
  logic [BITS_MEMBERS-1:0] beat_count;
  logic                    accept;

  assign accept = clken && s_valid_config && resetn_config && !count_config_full;

  // write goes out in the cycle the beat is offered
  always_comb begin
    cfg_write.en        = accept;
    cfg_write.to_offset = (beat_count == '0);
    // member index is one behind the beat count
    cfg_write.addr      = beat_count - BITS_MEMBERS'(1);
    cfg_write.word      = s_config;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_count        <= '0;
      count_config_full <= 1'b0;
    end else if (clken) begin
      if (!resetn_config) begin
        // restart the load
        beat_count        <= '0;
        count_config_full <= 1'b0;
      end else if (accept) begin
        if (beat_count == BITS_MEMBERS'(MEMBERS)) begin
          // last member written, ignore further beats
          count_config_full <= 1'b1;
        end else begin
          beat_count <= beat_count + BITS_MEMBERS'(1);
        end
      end
    end
  end

endmodule

// File: rtl/lrelu_datapath.sv
module lrelu_datapath (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      clken,
  input  lrelu_pkg::beat_in_t                                       beat,
  input  lrelu_pkg::coef_t                                          coef,
  input  logic signed [lrelu_pkg::WORD_WIDTH_OUT-1:0]               offset,
  output logic                                                      m_valid,
  output logic                                                      m_last,
  output lrelu_pkg::user_t                                          m_user,
  output logic [lrelu_pkg::UNITS-1:0][lrelu_pkg::WORD_WIDTH_OUT-1:0] m_data
);
  import lrelu_pkg::*;

  logic                             valid_1;
  logic                             last_1;
  user_t                            user_1;
  logic signed [WORD_WIDTH_OUT-1:0] offset_1;
  logic signed [WORD_WIDTH_PROD-1:0] sum_1 [UNITS];

  // x * scale + bias, all sign extended to the internal width
  function automatic logic signed [WORD_WIDTH_PROD-1:0] mul_add(
    input logic signed [WORD_WIDTH_IN-1:0] x,
    input coef_t                           c
  );
    logic signed [WORD_WIDTH_PROD-1:0] x_ext;
    x_ext = WORD_WIDTH_PROD'(x);
    return x_ext * WORD_WIDTH_PROD'(c.scale) + WORD_WIDTH_PROD'(c.bias);
  endfunction

  // leaky slope, requantization shift, offset and clamp
  function automatic logic [WORD_WIDTH_OUT-1:0] requant(
    input logic signed [WORD_WIDTH_PROD-1:0] t,
    input logic                              is_lrelu,
    input logic signed [WORD_WIDTH_OUT-1:0]  d
  );
    logic signed [WORD_WIDTH_PROD-1:0] r;
    logic signed [WORD_WIDTH_PROD-1:0] sat_max;
    logic signed [WORD_WIDTH_PROD-1:0] sat_min;
    sat_max = 2 ** (WORD_WIDTH_OUT - 1) - 1;
    sat_min = -(2 ** (WORD_WIDTH_OUT - 1));
    r = t;
    if (is_lrelu && t < 0) r = r >>> ALPHA_SHIFT;
    r = (r >>> FRAC_SHIFT) + WORD_WIDTH_PROD'(d);
    if (r > sat_max) return sat_max[WORD_WIDTH_OUT-1:0];
    if (r < sat_min) return sat_min[WORD_WIDTH_OUT-1:0];
    return r[WORD_WIDTH_OUT-1:0];
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_1 <= 1'b0;
      last_1  <= 1'b0;
      m_valid <= 1'b0;
      m_last  <= 1'b0;
    end else if (clken) begin
      valid_1 <= beat.valid;
      last_1  <= beat.last;
      m_valid <= valid_1;
      m_last  <= last_1;
    end
  end

  // stage one, multiply-add per lane
  always_ff @(posedge clk) begin
    if (clken && beat.valid) begin
      user_1   <= beat.user;
      offset_1 <= offset;
      for (int u = 0; u < UNITS; u++) sum_1[u] <= mul_add(beat.data[u], coef);
    end
  end

  // stage two, activation and saturation
  always_ff @(posedge clk) begin
    if (clken && valid_1) begin
      m_user <= user_1;
      for (int u = 0; u < UNITS; u++) m_data[u] <= requant(sum_1[u], user_1.is_lrelu, offset_1);
    end
  end

endmodule

// File: rtl/lrelu_engine.sv
module lrelu_engine (
  input  logic                                                      clk,
  input  logic                                                      rst_n,
  input  logic                                                      clken,
  input  logic                                                      s_valid,
  input  logic                                                      s_last,
  input  lrelu_pkg::user_t                                          s_user,
  input  logic [lrelu_pkg::UNITS-1:0][lrelu_pkg::WORD_WIDTH_IN-1:0]  s_data,
  output logic                                                      m_valid,
  output logic                                                      m_last,
  output lrelu_pkg::user_t                                          m_user,
  output logic [lrelu_pkg::UNITS-1:0][lrelu_pkg::WORD_WIDTH_OUT-1:0] m_data,
  input  logic                                                      resetn_config,
  input  logic                                                      s_valid_config,
  input  lrelu_pkg::cfg_word_u                                      s_config,
  output logic                                                      count_config_full
);
  import lrelu_pkg::*;

  cfg_write_t                       cfg_write;
  beat_in_t                         beat;
  coef_t                            coef;
  logic signed [WORD_WIDTH_OUT-1:0] offset;

  // producer, counts config beats
  lrelu_config_loader config_loader_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .clken            (clken),
    .resetn_config    (resetn_config),
    .s_valid_config   (s_valid_config),
    .s_config         (s_config),
    .cfg_write        (cfg_write),
    .count_config_full(count_config_full)
  );

  // buffer, coefficient store and first stage
  lrelu_coef_bank coef_bank_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .clken        (clken),
    .resetn_config(resetn_config),
    .cfg_write    (cfg_write),
    .s_valid      (s_valid),
    .s_last       (s_last),
    .s_user       (s_user),
    .s_data       (s_data),
    .beat         (beat),
    .coef         (coef),
    .offset       (offset)
  );

  // consumer, two arithmetic stages
  lrelu_datapath datapath_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .clken  (clken),
    .beat   (beat),
    .coef   (coef),
    .offset (offset),
    .m_valid(m_valid),
    .m_last (m_last),
    .m_user (m_user),
    .m_data (m_data)
  );

endmodule

// File: rtl/lrelu_pkg.sv
package lrelu_pkg;

  // array geometry
  localparam int UNITS        = 4;
  localparam int MEMBERS      = 12;
  localparam int KW_MAX       = 3;
  localparam int BITS_KW2     = 1;
  localparam int BITS_MEMBERS = 4;

  // word widths
  localparam int WORD_WIDTH_IN     = 16;
  localparam int WORD_WIDTH_OUT    = 8;
  localparam int WORD_WIDTH_CONFIG = 24;
  localparam int WORD_WIDTH_PROD   = 32;

  // alpha of 0.1 approximated as a shift by 3
  localparam int ALPHA_SHIFT = 3;
  localparam int FRAC_SHIFT  = 6;

  typedef struct packed {
    logic signed [WORD_WIDTH_OUT-1:0] scale;
    logic signed [WORD_WIDTH_IN-1:0]  bias;
  } coef_t;

  // beat 0 of a config load carries D in the low byte
  typedef struct packed {
    logic [WORD_WIDTH_CONFIG-WORD_WIDTH_OUT-1:0] reserved;
    logic signed [WORD_WIDTH_OUT-1:0]            d;
  } offset_word_t;

  typedef union packed {
    coef_t        coef;
    offset_word_t offset;
  } cfg_word_u;

  typedef struct packed {
    logic [BITS_KW2-1:0] kw2;
    logic                is_lrelu;
    logic [1:0]          tag;
  } user_t;

  typedef struct packed {
    logic                                valid;
    logic                                last;
    user_t                               user;
    logic [UNITS-1:0][WORD_WIDTH_IN-1:0] data;
  } beat_in_t;

  typedef struct packed {
    logic                    en;
    logic                    to_offset;
    logic [BITS_MEMBERS-1:0] addr;
    cfg_word_u               word;
  } cfg_write_t;

  // last read address of the cyclic coefficient read for a kernel width
  function automatic logic [BITS_MEMBERS-1:0] r_addr_max_lut(input logic [BITS_KW2-1:0] kw2);
    int kw;
    kw = 2 * int'(kw2) + 1;
    // widths past the largest kernel fall back to the full table
    if (kw > KW_MAX) kw = 1;
    return BITS_MEMBERS'(MEMBERS / kw - 1);
  endfunction

endpackage

// File: verification/lrelu_engine_assertions.sv
module lrelu_engine_assertions (
  input logic clk,
  input logic rst_n,
  input logic clken,
  input logic s_valid,
  input logic m_valid,
  input logic resetn_config,
  input logic count_config_full
);

  // s_valid at the last three clken edges
  logic [2:0] valid_hist;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_hist <= '0;
    end else if (clken) begin
      valid_hist <= {valid_hist[1:0], s_valid};
    end
  end

  reset_outputs_low: assert property (
    @(posedge clk) !rst_n |-> !m_valid && !count_config_full
  ) else $error("m_valid or count_config_full high during reset");

  // only a config reset at a clken edge clears the full flag
  full_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
      count_config_full && !(clken && !resetn_config) |=> count_config_full
  ) else $error("count_config_full dropped without a config reset");

  output_has_input: assert property (
    @(posedge clk) disable iff (!rst_n) clken && m_valid |-> valid_hist[2]
  ) else $error("m_valid without a beat accepted three clken edges earlier");

endmodule

bind lrelu_engine lrelu_engine_assertions lrelu_engine_assertions_i (
  .clk              (clk),
  .rst_n            (rst_n),
  .clken            (clken),
  .s_valid          (s_valid),
  .m_valid          (m_valid),
  .resetn_config    (resetn_config),
  .count_config_full(count_config_full)
);

// File: verification/lrelu_engine_tb.sv
module lrelu_engine_tb;
  import lrelu_pkg::*;

  localparam int RUN_LEN     = 30;
  localparam int N_DATA      = 200;
  // two loads, extra config beats, config reset, data runs
  localparam int TOTAL_BEATS = 2 * (MEMBERS + 1) + 36 + 3 * N_DATA + 8 * RUN_LEN;
  localparam int CYCLE_LIMIT = 2 * TOTAL_BEATS + 300;
  localparam int LINEAR      = 0;
  localparam int LEAKY       = 1;
  localparam int MIXED       = 2;

  typedef struct packed {
    logic                                valid;
    logic                                last;
    user_t                               user;
    logic [UNITS-1:0][WORD_WIDTH_IN-1:0] data;
    logic                                valid_config;
    cfg_word_u                           cfg;
    logic                                resetn_config;
  } stim_t;

  typedef struct packed {
    logic                                 last;
    user_t                                user;
    logic [UNITS-1:0][WORD_WIDTH_OUT-1:0] data;
  } out_beat_t;

  logic                                 clk;
  logic                                 rst_n;
  logic                                 clken;
  logic                                 s_valid;
  logic                                 s_last;
  user_t                                s_user;
  logic [UNITS-1:0][WORD_WIDTH_IN-1:0]  s_data;
  logic                                 m_valid;
  logic                                 m_last;
  user_t                                m_user;
  logic [UNITS-1:0][WORD_WIDTH_OUT-1:0] m_data;
  logic                                 resetn_config;
  logic                                 s_valid_config;
  cfg_word_u                            s_config;
  logic                                 count_config_full;

  logic [31:0]                      lfsr_state;
  logic signed [WORD_WIDTH_OUT-1:0] ref_d;
  coef_t                            ref_coef [MEMBERS];
  logic                             ref_full;
  int                               ref_count;
  int                               ref_ptr;
  out_beat_t                        expected_q [$];
  string                            test_name;
  int                               test_errors;
  int                               test_checked;
  int                               total_errors = 0;
  int                               total_checked = 0;
  int                               tests_done = 0;
  int                               cycle_count = 0;

  lrelu_engine lrelu_engine_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // arithmetic shift written as a division rounding towards minus infinity
  function automatic longint shift_floor(input longint v, input int s);
    longint p;
    longint q;
    p = longint'(1) << s;
    q = v / p;
    if (v < 0 && q * p != v) q = q - 1;
    return q;
  endfunction

  function automatic logic [WORD_WIDTH_OUT-1:0] expect_lane(
    input logic signed [WORD_WIDTH_IN-1:0]  x,
    input coef_t                            c,
    input logic                             leaky,
    input logic signed [WORD_WIDTH_OUT-1:0] d
  );
    longint t;
    t = longint'(x) * longint'($signed(c.scale)) + longint'($signed(c.bias));
    if (leaky && t < 0) t = shift_floor(t, ALPHA_SHIFT);
    t = shift_floor(t, FRAC_SHIFT) + longint'(d);
    if (t > 127) t = 127;
    if (t < -128) t = -128;
    return t[WORD_WIDTH_OUT-1:0];
  endfunction

  function automatic stim_t idle_stim();
    stim_t st;
    st = '0;
    st.resetn_config = 1'b1;
    return st;
  endfunction

  function automatic stim_t cfg_stim(input cfg_word_u w);
    stim_t st;
    st = idle_stim();
    st.valid_config = 1'b1;
    st.cfg = w;
    return st;
  endfunction

  function automatic user_t rand_user(input logic kw2, input logic leaky);
    user_t       user;
    logic [31:0] r;
    r = rand_bits(2);
    user.kw2 = kw2;
    user.is_lrelu = leaky;
    user.tag = r[1:0];
    return user;
  endfunction

  // mostly small words, a quarter full width to reach saturation
  function automatic stim_t data_stim(input user_t user);
    stim_t       st;
    logic [31:0] r;
    st = idle_stim();
    st.valid = 1'b1;
    st.user = user;
    r = rand_bits(3);
    st.last = (r == 0);
    for (int u = 0; u < UNITS; u++) begin
      r = rand_bits(2);
      if (r == 0) begin
        r = rand_bits(16);
        st.data[u] = r[15:0];
      end else begin
        r = rand_bits(8);
        st.data[u] = {{8{r[7]}}, r[7:0]};
      end
    end
    return st;
  endfunction

  // holds the inputs until an edge with clken high takes them
  task automatic offer(input stim_t st);
    logic ce;
    do begin
      ce = (rand_bits(3) != 0);
      @(posedge clk);
      clken          <= ce;
      s_valid        <= st.valid;
      s_last         <= st.last;
      s_user         <= st.user;
      s_data         <= st.data;
      s_valid_config <= st.valid_config;
      s_config       <= st.cfg;
      resetn_config  <= st.resetn_config;
    end while (!ce);
  endtask

  task automatic count_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic report_value(input string what, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("[ERROR] %s %s expected %h actual %h", test_name, what, exp_v, act_v);
    count_error();
  endtask

  task automatic clear_model();
    ref_d     = '0;
    ref_full  = 1'b0;
    ref_count = 0;
    ref_ptr   = 0;
    foreach (ref_coef[i]) ref_coef[i] = '0;
  endtask

  task automatic check_output();
    out_beat_t e;
    if (expected_q.size() == 0) begin
      $display("%s: output beat arrived with no input beat pending", test_name);
      count_error();
    end else begin
      e = expected_q.pop_front();
      test_checked++;
      total_checked++;
      if (m_data !== e.data) report_value("m_data", e.data, m_data);
      if (m_last !== e.last) report_value("m_last", {31'd0, e.last}, {31'd0, m_last});
      if (m_user !== e.user) report_value("m_user", {28'd0, e.user}, {28'd0, m_user});
    end
  endtask

  task automatic push_expected();
    out_beat_t e;
    e.last = s_last;
    e.user = s_user;
    for (int u = 0; u < UNITS; u++)
      e.data[u] = expect_lane(s_data[u], ref_coef[ref_ptr], s_user.is_lrelu, ref_d);
    expected_q.push_back(e);
  endtask

  task automatic update_model();
    int kw;
    if (!resetn_config) begin
      clear_model();
    end else begin
      if (s_valid) begin
        kw = 2 * int'(s_user.kw2) + 1;
        if (ref_ptr >= MEMBERS / kw - 1) ref_ptr = 0;
        else ref_ptr++;
      end
      if (s_valid_config && !ref_full) begin
        if (ref_count == 0) ref_d = s_config.offset.d;
        else ref_coef[ref_count - 1] = s_config.coef;
        if (ref_count == MEMBERS) ref_full = 1'b1;
        else ref_count++;
      end
    end
  endtask

  // model and checker see the values present before each edge
  always @(posedge clk) begin
    if (rst_n && clken) begin
      if (m_valid) check_output();
      if (count_config_full !== ref_full)
        report_value("count_config_full", {31'd0, ref_full}, {31'd0, count_config_full});
      if (s_valid) push_expected();
      update_model();
    end
  end

  // offset beat, then MEMBERS scale/bias pairs with a small bias
  task automatic load_config();
    logic [31:0] r;
    cfg_word_u   w;
    r = rand_bits(24);
    w = r[23:0];
    offer(cfg_stim(w));
    for (int k = 0; k < MEMBERS; k++) begin
      r = rand_bits(24);
      w = r[23:0];
      w.coef.bias = {{6{r[9]}}, r[9:0]};
      offer(cfg_stim(w));
    end
  endtask

  task automatic run_data(input int n, input int mode);
    logic [31:0] r;
    logic        leaky;
    for (int i = 0; i < n; i++) begin
      r = rand_bits(2);
      leaky = (mode == LEAKY) || (mode == MIXED && r[1]);
      offer(data_stim(rand_user(r[0], leaky)));
      r = rand_bits(2);
      if (r == 0) offer(idle_stim());
    end
  endtask

  // runs of one kernel width, alternating between wrap at 11 and at 3
  task automatic run_cyclic();
    logic [31:0] r;
    for (int run = 0; run < 8; run++) begin
      for (int i = 0; i < RUN_LEN; i++) begin
        r = rand_bits(1);
        offer(data_stim(rand_user(1'(run % 2), r[0])));
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    test_errors  = 0;
    test_checked = 0;
  endtask

  task automatic finish_test();
    int waited;
    waited = 0;
    offer(idle_stim());
    @(negedge clk);
    while (expected_q.size() != 0 && waited < 16) begin
      offer(idle_stim());
      @(negedge clk);
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("%s: %0d expected beats never came out", test_name, expected_q.size());
      expected_q.delete();
      count_error();
    end
    $display("test %s: %0d beats checked, %0d errors", test_name, test_checked, test_errors);
    tests_done++;
  endtask

  initial begin
    stim_t       st;
    logic [31:0] r;
    lfsr_state     = 32'hd4c3;
    rst_n          = 1'b0;
    clken          = 1'b0;
    s_valid        = 1'b0;
    s_last         = 1'b0;
    s_user         = '0;
    s_data         = '0;
    resetn_config  = 1'b1;
    s_valid_config = 1'b0;
    s_config       = '0;
    clear_model();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    start_test("reset_and_load");
    if (m_valid !== 1'b0 || count_config_full !== 1'b0) begin
      $display("reset_and_load: m_valid or count_config_full high after reset");
      count_error();
    end
    load_config();
    offer(idle_stim());
    @(negedge clk);
    if (count_config_full !== 1'b1) begin
      $display("reset_and_load: count_config_full did not rise after a full load");
      count_error();
    end
    // offered while full, must be ignored
    for (int i = 0; i < 3; i++) begin
      r = rand_bits(24);
      offer(cfg_stim(r[23:0]));
    end
    run_data(24, MIXED);
    finish_test();

    start_test("linear");
    run_data(N_DATA, LINEAR);
    finish_test();

    start_test("leaky");
    run_data(N_DATA, LEAKY);
    finish_test();

    start_test("cyclic_read");
    run_cyclic();
    finish_test();

    start_test("reload");
    st = idle_stim();
    st.resetn_config = 1'b0;
    offer(st);
    // beats before the new load see cleared coefficients and offset
    run_data(8, MIXED);
    load_config();
    run_data(N_DATA, MIXED);
    finish_test();

    $display("summary: %0d tests, %0d beats checked, %0d errors",
             tests_done, total_checked, total_errors);
    if (total_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
